// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_memory_puzzle
FILELIST  ?= memory_puzzle.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= PASS: all tests

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== hw/button_conditioner.sv ====
`timescale 1ns/1ps

module button_conditioner #(
    parameter int DEBOUNCE_LEN = 7
) (
    input  logic clk,
    input  logic rst,
    input  logic btn_i,
    output logic pulse_o
);
    logic [DEBOUNCE_LEN-1:0] shift_q;
    logic                    pressed;
    logic                    pressed_d_q;
    logic                    pulse_q;

    // Stable only when every sample is high
    assign pressed = &shift_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            shift_q     <= '0;
            pressed_d_q <= 1'b0;
            pulse_q     <= 1'b0;
        end else begin
            shift_q     <= {shift_q[DEBOUNCE_LEN-2:0], btn_i};
            pressed_d_q <= pressed;
            pulse_q     <= pressed && !pressed_d_q;
        end
    end

    assign pulse_o = pulse_q;
endmodule

// ==== hw/game_ctrl.sv ====
`timescale 1ns/1ps

module game_ctrl (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start_i,
    input  logic                   hint_i,
    input  logic                   key_valid_i,
    input  puzzle_pkg::key_t       key_i,
    output puzzle_pkg::tile_mask_t visible_o,
    output puzzle_pkg::tile_mask_t flip_o,
    output logic                   pass_o
);
    puzzle_pkg::game_state_t state_q;
    puzzle_pkg::tile_mask_t  visible_q;
    puzzle_pkg::tile_mask_t  flip_q;
    puzzle_pkg::tile_mask_t  solved_q;
    puzzle_pkg::tile_idx_t   pending_q;
    logic                    pending_valid_q;
    logic                    flip_armed_q;
    logic [3:0]              win_cnt_q;
    logic                    pass_q;

    puzzle_pkg::tile_idx_t   key_tile;
    logic                    is_tile_key;
    logic                    pair_match;

    assign key_tile    = key_i[3:0];
    assign is_tile_key = key_i < puzzle_pkg::NUM_TILES;

    // Distinct tiles, same image, same orientation, neither already solved
    assign pair_match = (pending_q != key_tile)
                     && (puzzle_pkg::img_id_t'(pending_q) == puzzle_pkg::img_id_t'(key_tile))
                     && (flip_q[pending_q] == flip_q[key_tile])
                     && !solved_q[pending_q]
                     && !solved_q[key_tile];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q         <= puzzle_pkg::GS_INIT;
            visible_q       <= '0;
            flip_q          <= puzzle_pkg::INIT_FLIP;
            solved_q        <= '0;
            pending_q       <= '0;
            pending_valid_q <= 1'b0;
            flip_armed_q    <= 1'b0;
            win_cnt_q       <= '0;
            pass_q          <= 1'b0;
        end else begin
            case (state_q)
                puzzle_pkg::GS_INIT: begin
                    visible_q       <= '0;
                    flip_q          <= puzzle_pkg::INIT_FLIP;
                    solved_q        <= '0;
                    pending_valid_q <= 1'b0;
                    flip_armed_q    <= 1'b0;
                    win_cnt_q       <= '0;
                    if (start_i) begin
                        state_q <= puzzle_pkg::GS_SHOW;
                    end
                end
                puzzle_pkg::GS_SHOW: begin
                    visible_q <= '1;
                    if (start_i) begin
                        state_q   <= puzzle_pkg::GS_GAME;
                        visible_q <= '0;
                    end
                end
                puzzle_pkg::GS_GAME: begin
                    if (win_cnt_q == 4'(puzzle_pkg::WIN_PAIRS)) begin
                        state_q   <= puzzle_pkg::GS_FINISH;
                        visible_q <= '1;
                        pass_q    <= 1'b1;
                    end else begin
                        if (hint_i) begin
                            visible_q <= '1;
                        end
                        if (key_valid_i) begin
                            if (key_i == puzzle_pkg::KEY_FLIP) begin
                                flip_armed_q <= 1'b1;
                            end else if (key_i == puzzle_pkg::KEY_ENTER) begin
                                visible_q <= solved_q;
                            end else if (is_tile_key) begin
                                visible_q[key_tile] <= 1'b1;
                                if (flip_armed_q) begin
                                    flip_q[key_tile] <= !flip_q[key_tile];
                                    flip_armed_q     <= 1'b0;
                                end else if (!pending_valid_q) begin
                                    pending_q       <= key_tile;
                                    pending_valid_q <= 1'b1;
                                end else begin
                                    pending_valid_q <= 1'b0;
                                    if (pair_match) begin
                                        solved_q[key_tile]  <= 1'b1;
                                        solved_q[pending_q] <= 1'b1;
                                        win_cnt_q           <= win_cnt_q + 1'b1;
                                    end
                                end
                            end
                        end
                    end
                end
                puzzle_pkg::GS_FINISH: begin
                    visible_q <= '1;
                    pass_q    <= 1'b1;
                end
                default: begin
                    state_q <= puzzle_pkg::GS_INIT;
                end
            endcase
        end
    end

    assign visible_o = visible_q;
    assign flip_o    = flip_q;
    assign pass_o    = pass_q;

    win_cnt_bounded: assert property (@(posedge clk) disable iff (rst)
        win_cnt_q <= puzzle_pkg::WIN_PAIRS);
    pass_only_finish: assert property (@(posedge clk) disable iff (rst)
        pass_o |-> state_q == puzzle_pkg::GS_FINISH);
endmodule

// ==== hw/memory_puzzle_top.sv ====
`timescale 1ns/1ps

module memory_puzzle_top #(
    parameter int TILE_W       = 80,
    parameter int TILE_H       = 60,
    parameter int H_ACTIVE     = 640,
    parameter int H_FRONT      = 16,
    parameter int H_SYNC       = 96,
    parameter int H_BACK       = 48,
    parameter int V_ACTIVE     = 480,
    parameter int V_FRONT      = 10,
    parameter int V_SYNC       = 2,
    parameter int V_BACK       = 33,
    parameter int DEBOUNCE_LEN = 7
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  start_i,
    input  logic                  hint_i,
    input  logic                  key_valid_i,
    input  puzzle_pkg::key_t      key_i,
    input  puzzle_pkg::color_t    img_pixel_i,
    output logic                  hsync_o,
    output logic                  vsync_o,
    output logic [3:0]            red_o,
    output logic [3:0]            green_o,
    output logic [3:0]            blue_o,
    output puzzle_pkg::pix_addr_t img_addr_o,
    output puzzle_pkg::img_id_t   img_id_o,
    output logic                  pass_o
);
    logic                   start_pulse;
    logic                   hint_pulse;
    puzzle_pkg::coord_t     h_cnt;
    puzzle_pkg::coord_t     v_cnt;
    logic                   active;
    logic                   hsync;
    logic                   vsync;
    puzzle_pkg::tile_mask_t visible;
    puzzle_pkg::tile_mask_t flip;
    puzzle_pkg::tile_idx_t  tile;

    button_conditioner #(.DEBOUNCE_LEN(DEBOUNCE_LEN)) start_btn_i (
        .clk(clk), .rst(rst), .btn_i(start_i), .pulse_o(start_pulse)
    );

    button_conditioner #(.DEBOUNCE_LEN(DEBOUNCE_LEN)) hint_btn_i (
        .clk(clk), .rst(rst), .btn_i(hint_i), .pulse_o(hint_pulse)
    );

    vga_timing #(
        .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
        .V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
    ) vga_timing_i (
        .clk(clk), .rst(rst), .h_cnt_o(h_cnt), .v_cnt_o(v_cnt),
        .active_o(active), .hsync_o(hsync), .vsync_o(vsync)
    );

    tile_mapper #(.TILE_W(TILE_W), .TILE_H(TILE_H)) tile_mapper_i (
        .h_cnt_i(h_cnt), .v_cnt_i(v_cnt), .flip_i(flip),
        .tile_o(tile), .img_id_o(img_id_o), .addr_o(img_addr_o)
    );

    game_ctrl game_ctrl_i (
        .clk(clk), .rst(rst), .start_i(start_pulse), .hint_i(hint_pulse),
        .key_valid_i(key_valid_i), .key_i(key_i),
        .visible_o(visible), .flip_o(flip), .pass_o(pass_o)
    );

    pixel_output pixel_output_i (
        .clk(clk), .rst(rst), .active_i(active), .hsync_i(hsync), .vsync_i(vsync),
        .tile_i(tile), .visible_i(visible), .img_pixel_i(img_pixel_i),
        .hsync_o(hsync_o), .vsync_o(vsync_o),
        .red_o(red_o), .green_o(green_o), .blue_o(blue_o)
    );
endmodule

// ==== hw/pixel_output.sv ====
`timescale 1ns/1ps

module pixel_output (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   active_i,
    input  logic                   hsync_i,
    input  logic                   vsync_i,
    input  puzzle_pkg::tile_idx_t  tile_i,
    input  puzzle_pkg::tile_mask_t visible_i,
    input  puzzle_pkg::color_t     img_pixel_i,
    output logic                   hsync_o,
    output logic                   vsync_o,
    output logic [3:0]             red_o,
    output logic [3:0]             green_o,
    output logic [3:0]             blue_o
);
    logic                  active_q;
    logic                  hsync_q;
    logic                  vsync_q;
    puzzle_pkg::tile_idx_t tile_q;
    logic                  show;

    // One stage to meet the ROM read
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            active_q <= 1'b0;
            hsync_q  <= 1'b1;
            vsync_q  <= 1'b1;
            tile_q   <= '0;
        end else begin
            active_q <= active_i;
            hsync_q  <= hsync_i;
            vsync_q  <= vsync_i;
            tile_q   <= tile_i;
        end
    end

    assign show    = active_q && visible_i[tile_q];
    assign red_o   = show ? img_pixel_i[11:8] : 4'h0;
    assign green_o = show ? img_pixel_i[7:4] : 4'h0;
    assign blue_o  = show ? img_pixel_i[3:0] : 4'h0;
    assign hsync_o = hsync_q;
    assign vsync_o = vsync_q;
endmodule

// ==== hw/puzzle_pkg.sv ====
package puzzle_pkg;

    // 4 bits each of red, green, blue
    typedef logic [11:0] color_t;

    // Row-major tile number on the 4x4 grid
    typedef logic [3:0]  tile_idx_t;
    typedef logic [15:0] tile_mask_t;
    typedef logic [2:0]  img_id_t;

    // Decoded key number where 0 to 15 select a tile
    typedef logic [4:0]  key_t;

    typedef logic [9:0]  coord_t;
    typedef logic [12:0] pix_addr_t;

    typedef enum logic [1:0] {
        GS_INIT,
        GS_SHOW,
        GS_GAME,
        GS_FINISH
    } game_state_t;

    localparam key_t KEY_FLIP  = 5'd16;
    localparam key_t KEY_ENTER = 5'd17;

    localparam int NUM_TILES = 16;
    localparam int WIN_PAIRS = 8;

    // Tiles 0, 2 and 3 start upside down
    localparam tile_mask_t INIT_FLIP = 16'h000D;

endpackage

// ==== hw/tile_mapper.sv ====
`timescale 1ns/1ps

module tile_mapper #(
    parameter int TILE_W = 80,
    parameter int TILE_H = 60
) (
    input  puzzle_pkg::coord_t     h_cnt_i,
    input  puzzle_pkg::coord_t     v_cnt_i,
    input  puzzle_pkg::tile_mask_t flip_i,
    output puzzle_pkg::tile_idx_t  tile_o,
    output puzzle_pkg::img_id_t    img_id_o,
    output puzzle_pkg::pix_addr_t  addr_o
);
    puzzle_pkg::coord_t x;
    puzzle_pkg::coord_t y;
    puzzle_pkg::coord_t img_col;
    puzzle_pkg::coord_t img_row;
    logic [1:0]         grid_col;
    logic [1:0]         grid_row;

    always_comb begin
        // Each image pixel covers 2x2 screen pixels
        x        = h_cnt_i >> 1;
        y        = v_cnt_i >> 1;
        grid_col = 2'(x / TILE_W);
        grid_row = 2'(y / TILE_H);
        tile_o   = {grid_row, grid_col};
        img_id_o = tile_o[2:0];
        img_col  = puzzle_pkg::coord_t'(x % TILE_W);
        img_row  = puzzle_pkg::coord_t'(y % TILE_H);
        if (flip_i[tile_o]) begin
            img_row = puzzle_pkg::coord_t'(TILE_H - 1) - img_row;
        end
        addr_o = puzzle_pkg::pix_addr_t'(img_row * TILE_W + img_col);
    end
endmodule

// ==== hw/vga_timing.sv ====
`timescale 1ns/1ps

module vga_timing #(
    parameter int H_ACTIVE = 640,
    parameter int H_FRONT  = 16,
    parameter int H_SYNC   = 96,
    parameter int H_BACK   = 48,
    parameter int V_ACTIVE = 480,
    parameter int V_FRONT  = 10,
    parameter int V_SYNC   = 2,
    parameter int V_BACK   = 33
) (
    input  logic               clk,
    input  logic               rst,
    output puzzle_pkg::coord_t h_cnt_o,
    output puzzle_pkg::coord_t v_cnt_o,
    output logic               active_o,
    output logic               hsync_o,
    output logic               vsync_o
);
    localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
    localparam int H_SYNC_START = H_ACTIVE + H_FRONT;
    localparam int V_SYNC_START = V_ACTIVE + V_FRONT;

    puzzle_pkg::coord_t pix_q;
    puzzle_pkg::coord_t line_q;
    puzzle_pkg::coord_t pix_next;
    puzzle_pkg::coord_t line_next;
    logic               hsync_q;
    logic               vsync_q;

    always_comb begin
        pix_next  = pix_q + 1'b1;
        line_next = line_q;
        if (pix_q == puzzle_pkg::coord_t'(H_TOTAL - 1)) begin
            pix_next = '0;
            if (line_q == puzzle_pkg::coord_t'(V_TOTAL - 1)) begin
                line_next = '0;
            end else begin
                line_next = line_q + 1'b1;
            end
        end
    end

    // Syncs decoded from the next count so they line up with the counters
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pix_q   <= '0;
            line_q  <= '0;
            hsync_q <= 1'b1;
            vsync_q <= 1'b1;
        end else begin
            pix_q   <= pix_next;
            line_q  <= line_next;
            hsync_q <= !(pix_next >= H_SYNC_START && pix_next < H_SYNC_START + H_SYNC);
            vsync_q <= !(line_next >= V_SYNC_START && line_next < V_SYNC_START + V_SYNC);
        end
    end

    assign active_o = (pix_q < H_ACTIVE) && (line_q < V_ACTIVE);
    assign h_cnt_o  = (pix_q < H_ACTIVE) ? pix_q : '0;
    assign v_cnt_o  = (line_q < V_ACTIVE) ? line_q : '0;
    assign hsync_o  = hsync_q;
    assign vsync_o  = vsync_q;

    counters_in_range: assert property (@(posedge clk) disable iff (rst)
        pix_q < H_TOTAL && line_q < V_TOTAL);
endmodule

// ==== memory_puzzle.f ====
hw/puzzle_pkg.sv
hw/button_conditioner.sv
hw/vga_timing.sv
hw/tile_mapper.sv
hw/game_ctrl.sv
hw/pixel_output.sv
hw/memory_puzzle_top.sv
verification/tb_memory_puzzle.sv

// ==== verification/memory_puzzle_stimulus.txt ====
# cmd arg visible flip pass: cmd S start press, H hint press, K key with decimal arg
# visible and flip are hex masks with bit n for tile n, pass is the expected pass_o
S 0 ffff 000d 0
S 0 0000 000d 0
K 1 0002 000d 0
K 9 0202 000d 0
K 0 0203 000d 0
K 8 0303 000d 0
K 17 0202 000d 0
K 16 0202 000d 0
K 0 0203 000c 0
K 0 0203 000c 0
K 8 0303 000c 0
H 0 ffff 000c 0
K 17 0303 000c 0
K 16 0303 000c 0
K 2 0307 0008 0
K 16 0307 0008 0
K 3 030f 0000 0
K 2 030f 0000 0
K 10 070f 0000 0
K 3 070f 0000 0
K 11 0f0f 0000 0
K 4 0f1f 0000 0
K 12 1f1f 0000 0
K 5 1f3f 0000 0
K 13 3f3f 0000 0
K 6 3f7f 0000 0
K 14 7f7f 0000 0
K 7 7fff 0000 0
K 15 ffff 0000 1

// ==== verification/tb_memory_puzzle.sv ====
`timescale 1ns/1ps

module tb_memory_puzzle;
    localparam int TILE_W       = 4;
    localparam int TILE_H       = 3;
    localparam int H_ACTIVE     = 32;
    localparam int H_FRONT      = 2;
    localparam int H_SYNC       = 4;
    localparam int H_BACK       = 2;
    localparam int V_ACTIVE     = 24;
    localparam int V_FRONT      = 1;
    localparam int V_SYNC       = 2;
    localparam int V_BACK       = 1;
    localparam int DEBOUNCE_LEN = 7;
    localparam int H_TOTAL      = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL      = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
    localparam int FRAME        = H_TOTAL * V_TOTAL;

    logic                   clk;
    logic                   rst;
    logic                   start_i;
    logic                   hint_i;
    logic                   key_valid_i;
    puzzle_pkg::key_t       key_i;
    puzzle_pkg::color_t     img_pixel_i;
    logic                   hsync_o;
    logic                   vsync_o;
    logic [3:0]             red_o;
    logic [3:0]             green_o;
    logic [3:0]             blue_o;
    puzzle_pkg::pix_addr_t  img_addr_o;
    puzzle_pkg::img_id_t    img_id_o;
    logic                   pass_o;

    puzzle_pkg::img_id_t    rom_id;
    puzzle_pkg::pix_addr_t  rom_addr;
    logic                   check_en;
    logic                   stim_loaded;
    puzzle_pkg::tile_mask_t exp_visible;
    puzzle_pkg::tile_mask_t exp_flip;
    int                     cur_h;
    int                     cur_v;
    int                     out_h;
    int                     out_v;
    logic                   out_valid;
    int                     step_errors;
    int                     total_errors;
    int                     failed_tests;
    int                     test_count;
    logic [31:0]            rng;
    longint                 limit_ns;

    byte                    cmds[$];
    int                     args[$];
    puzzle_pkg::tile_mask_t vis_exp[$];
    puzzle_pkg::tile_mask_t flip_exp[$];
    logic                   pass_exp[$];

    memory_puzzle_top #(
        .TILE_W(TILE_W), .TILE_H(TILE_H),
        .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
        .V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK),
        .DEBOUNCE_LEN(DEBOUNCE_LEN)
    ) dut_i (
        .clk(clk), .rst(rst), .start_i(start_i), .hint_i(hint_i),
        .key_valid_i(key_valid_i), .key_i(key_i), .img_pixel_i(img_pixel_i),
        .hsync_o(hsync_o), .vsync_o(vsync_o), .red_o(red_o), .green_o(green_o),
        .blue_o(blue_o), .img_addr_o(img_addr_o), .img_id_o(img_id_o), .pass_o(pass_o)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    function automatic logic [31:0] next_random();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    // Image id in the top bits, so a wrong image or a flipped row changes the color
    function automatic puzzle_pkg::color_t rom_color(input puzzle_pkg::img_id_t id,
                                                     input puzzle_pkg::pix_addr_t addr);
        return {1'b1, id, addr[7:0]};
    endfunction

    function automatic puzzle_pkg::color_t expected_color(input int h, input int v);
        int x;
        int y;
        int tile;
        int img_row;
        int addr;
        x = h / 2;
        y = v / 2;
        tile = (y / TILE_H) * 4 + x / TILE_W;
        if (!exp_visible[tile]) begin
            return '0;
        end
        img_row = y % TILE_H;
        if (exp_flip[tile]) begin
            img_row = TILE_H - 1 - img_row;
        end
        addr = img_row * TILE_W + x % TILE_W;
        return rom_color(puzzle_pkg::img_id_t'(tile % 8), puzzle_pkg::pix_addr_t'(addr));
    endfunction

    // One cycle read ROM model
    always @(negedge clk) begin
        rom_id   = img_id_o;
        rom_addr = img_addr_o;
    end

    always @(posedge clk) begin
        #2;
        img_pixel_i = rom_color(rom_id, rom_addr);
    end

    task automatic check_pixel();
        puzzle_pkg::color_t exp_color;
        logic               exp_hs;
        logic               exp_vs;
        exp_color = '0;
        exp_hs    = 1'b1;
        exp_vs    = 1'b1;
        if (out_valid) begin
            exp_hs = !(out_h >= H_ACTIVE + H_FRONT && out_h < H_ACTIVE + H_FRONT + H_SYNC);
            exp_vs = !(out_v >= V_ACTIVE + V_FRONT && out_v < V_ACTIVE + V_FRONT + V_SYNC);
            if (out_h < H_ACTIVE && out_v < V_ACTIVE) begin
                exp_color = expected_color(out_h, out_v);
            end
        end
        assert ({red_o, green_o, blue_o} == exp_color) else begin
            $display("MISMATCH at %0t: {red_o,green_o,blue_o} expected %h, got %h",
                     $time, exp_color, {red_o, green_o, blue_o});
            step_errors++;
        end
        assert (hsync_o == exp_hs) else begin
            $display("MISMATCH at %0t: hsync_o expected %b, got %b", $time, exp_hs, hsync_o);
            step_errors++;
        end
        assert (vsync_o == exp_vs) else begin
            $display("MISMATCH at %0t: vsync_o expected %b, got %b", $time, exp_vs, vsync_o);
            step_errors++;
        end
    endtask

    // Output lags the counters by one cycle
    always @(negedge clk) begin
        if (rst) begin
            cur_h     = 0;
            cur_v     = 0;
            out_valid = 1'b0;
        end else begin
            if (check_en) begin
                check_pixel();
            end
            out_h     = cur_h;
            out_v     = cur_v;
            out_valid = 1'b1;
            cur_h++;
            if (cur_h == H_TOTAL) begin
                cur_h = 0;
                cur_v = (cur_v == V_TOTAL - 1) ? 0 : cur_v + 1;
            end
        end
    end

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
        #2;
    endtask

    task automatic load_stimulus();
        int    fd;
        int    n;
        string line;
        byte   c;
        int    a;
        int    p;
        logic [15:0] v;
        logic [15:0] f;
        fd = $fopen("verification/memory_puzzle_stimulus.txt", "r");
        if (fd == 0) begin
            $display("Error: cannot open verification/memory_puzzle_stimulus.txt");
            total_errors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (n > 0 && line.len() > 1 && line.getc(0) != "#") begin
                    n = $sscanf(line, "%c %d %h %h %d", c, a, v, f, p);
                    if (n == 5) begin
                        cmds.push_back(c);
                        args.push_back(a);
                        vis_exp.push_back(v);
                        flip_exp.push_back(f);
                        pass_exp.push_back(p != 0);
                    end else begin
                        $display("Error: malformed stimulus line: %s", line);
                        total_errors++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic press_button(input logic hint);
        int len;
        len = DEBOUNCE_LEN + int'(next_random() % 16);
        if (hint) begin
            hint_i = 1'b1;
        end else begin
            start_i = 1'b1;
        end
        wait_cycles(len);
        hint_i  = 1'b0;
        start_i = 1'b0;
        wait_cycles(DEBOUNCE_LEN + 4);
    endtask

    task automatic send_key(input puzzle_pkg::key_t k);
        key_valid_i = 1'b1;
        key_i       = k;
        wait_cycles(1);
        key_valid_i = 1'b0;
        key_i       = '0;
    endtask

    task automatic check_frame(input logic exp_pass, input string name);
        check_en = 1'b1;
        wait_cycles(FRAME);
        check_en = 1'b0;
        assert (pass_o == exp_pass) else begin
            $display("MISMATCH at %0t: pass_o expected %b, got %b", $time, exp_pass, pass_o);
            step_errors++;
        end
        test_count++;
        if (step_errors == 0) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, step_errors);
            failed_tests++;
        end
        total_errors += step_errors;
        step_errors = 0;
    endtask

    initial begin
        wait (stim_loaded);
        limit_ns = longint'(cmds.size() + 1) * (3 * FRAME + 20) * 40;
        #(limit_ns);
        $display("Timeout: the tests did not finish in %0d ns", limit_ns);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        string name;
        rst          = 1'b1;
        start_i      = 1'b0;
        hint_i       = 1'b0;
        key_valid_i  = 1'b0;
        key_i        = '0;
        img_pixel_i  = '0;
        check_en     = 1'b0;
        stim_loaded  = 1'b0;
        exp_visible  = '0;
        exp_flip     = puzzle_pkg::INIT_FLIP;
        step_errors  = 0;
        total_errors = 0;
        failed_tests = 0;
        test_count   = 0;
        rng          = 32'd40;
        load_stimulus();
        stim_loaded = 1'b1;
        repeat (3) @(posedge clk);
        #2 rst = 1'b0;
        check_frame(1'b0, "after reset");
        for (int i = 0; i < cmds.size(); i++) begin
            case (cmds[i])
                "S": begin
                    press_button(1'b0);
                    name = "start press";
                end
                "H": begin
                    press_button(1'b1);
                    name = "hint press";
                end
                default: begin
                    send_key(puzzle_pkg::key_t'(args[i]));
                    name = $sformatf("key %0d", args[i]);
                end
            endcase
            wait_cycles(2 * FRAME);
            exp_visible = vis_exp[i];
            exp_flip    = flip_exp[i];
            check_frame(pass_exp[i], $sformatf("step %0d, %s", i + 1, name));
        end
        $display("tests %0d, failed %0d, errors %0d", test_count, failed_tests, total_errors);
        if (total_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end
endmodule
